// File: composite_enc.f
logic/composite_pkg.sv
logic/color_table_regs.sv
logic/line_timer.sv
logic/color_lut.sv
logic/chroma_gen.sv
logic/composite_mixer.sv
logic/composite_enc_top.sv
dv/composite_enc_tb.sv

// File: dv/composite_enc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module composite_enc_tb;

        localparam int          LINE_LEN       = 40;
        localparam logic [15:0] SUBCARRIER_INC = 16'd14564;

        localparam int RESET_CYCLES   = 3;
        localparam int DEFAULT_CYCLES = 200;
        localparam int ODD_CYCLES     = 200;
        localparam int BLANK_CYCLES   = 200;
        localparam int WRITE_CYCLES   = 300;
        localparam int DRAIN_CYCLES   = 3;
        localparam int CYCLE_LIMIT    = RESET_CYCLES + DEFAULT_CYCLES + ODD_CYCLES
                                      + BLANK_CYCLES + WRITE_CYCLES + DRAIN_CYCLES + 50;

        logic                      clk_dot4x;
        logic                      rst_n_i;
        composite_pkg::color_idx_t index_i;
        logic                      blank_i;
        logic                      tbl_we_i;
        composite_pkg::tbl_sel_e   tbl_sel_i;
        composite_pkg::color_idx_t tbl_addr_i;
        logic [7:0]                tbl_data_i;
        composite_pkg::comp_t      composite_o;

        composite_pkg::luma_t  m_luma  [16];     // model copies of the tables
        composite_pkg::amp_t   m_amp   [16];
        composite_pkg::phase_t m_phase [16];
        int                    exp_q [$];        // outputs of the next 3 edges
        int                    edge_no;          // upcoming edge, 1 is first after reset
        integer                seed;
        int                    check_cnt = 0;
        int                    err_cnt = 0;
        int                    test_cnt = 0;
        int                    cycle_cnt = 0;

        composite_enc_top #(
                .LINE_LEN       (LINE_LEN),
                .SUBCARRIER_INC (SUBCARRIER_INC)
        ) dut (
                .clk_dot4x   (clk_dot4x),
                .rst_n_i     (rst_n_i),
                .index_i     (index_i),
                .blank_i     (blank_i),
                .tbl_we_i    (tbl_we_i),
                .tbl_sel_i   (tbl_sel_i),
                .tbl_addr_i  (tbl_addr_i),
                .tbl_data_i  (tbl_data_i),
                .composite_o (composite_o)
        );

        always #10 clk_dot4x = ~clk_dot4x;

        always @(posedge clk_dot4x) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= CYCLE_LIMIT) begin
                        $display("timeout: the tests did not finish within %0d cycles",
                                 CYCLE_LIMIT);
                        $display("CHECKS FAILED");
                        $finish;
                end
        end

        function automatic bit line_is_odd(input int edge_i);
                return (((edge_i - 1) / LINE_LEN) % 2) == 1;
        endfunction

        function automatic int expected_sample(input logic [3:0] idx, input logic blk,
                                               input int edge_i);
                int         lum;
                int         amp;
                int         ph;
                int         acc_top;
                int         chroma;
                logic [5:0] sidx;
                if (blk) begin
                        return int'(composite_pkg::BLANK_LEVEL);
                end
                lum = int'(m_luma[idx]);
                amp = int'(m_amp[idx]);
                ph  = int'(m_phase[idx]);
                if (line_is_odd(edge_i)) begin
                        ph = (256 - ph) % 256;      // mirrored on odd lines
                end
                // stage 2 runs one edge later, accumulator then holds edge_i steps
                acc_top = ((edge_i * int'(SUBCARRIER_INC)) % 65536) / 256;
                sidx    = 6'(((acc_top + ph) % 256) / 4);
                if (amp == 7) begin
                        chroma = 0;
                end else begin
                        chroma = int'(composite_pkg::SINE_TABLE[sidx]) >>> amp;
                end
                return 4 * lum + int'(composite_pkg::CHROMA_OFFSET) + chroma;
        endfunction

        task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                                   input string what);
                check_cnt++;
                if (expected !== actual) begin
                        err_cnt++;
                        $display("error at %0t: %s expected %0d, got %0d",
                                 $time, what, expected, actual);
                end
        endtask

        task automatic note_failure(input string what);
                err_cnt++;
                $display("%s", what);
        endtask

        task automatic apply_write(input logic [1:0] sel, input logic [3:0] addr,
                                   input logic [7:0] data);
                case (sel)
                        2'd0: m_luma[addr] = data[5:0];
                        2'd1: m_amp[addr] = data[2:0];
                        2'd2: m_phase[addr] = data;
                        default: ;
                endcase
        endtask

        // one clock: check the last edge, then drive the item for the next one
        task automatic step(input logic [3:0] idx, input logic blk, input logic we,
                            input logic [1:0] sel, input logic [3:0] addr,
                            input logic [7:0] data);
                int exp_v;
                @(negedge clk_dot4x);
                exp_v = exp_q.pop_front();
                check_value(exp_v, composite_o, "composite sample");
                index_i    = idx;
                blank_i    = blk;
                tbl_we_i   = we;
                tbl_sel_i  = composite_pkg::tbl_sel_e'(sel);
                tbl_addr_i = addr;
                tbl_data_i = data;
                exp_q.push_back(expected_sample(idx, blk, edge_no));
                if (we) begin
                        apply_write(sel, addr, data);   // lookup sees it from next edge
                end
                edge_no++;
        endtask

        task automatic finish_test(input string name, input int checks0, input int errs0);
                test_cnt++;
                $display("%s: %0d checks, %0d errors", name, check_cnt - checks0,
                         err_cnt - errs0);
        endtask

        task automatic run_reset_test();
                int c0;
                int e0;
                c0 = check_cnt;
                e0 = err_cnt;
                repeat (RESET_CYCLES) begin
                        @(negedge clk_dot4x);
                        check_value(0, composite_o, "composite in reset");
                end
                rst_n_i = 1'b1;
                // empty stages after reset carry zero luma and chroma
                exp_q.push_back(int'(composite_pkg::CHROMA_OFFSET));
                exp_q.push_back(int'(composite_pkg::CHROMA_OFFSET));
                exp_q.push_back(expected_sample(4'd0, 1'b0, 1));
                edge_no = 2;
                finish_test("reset state", c0, e0);
        endtask

        task automatic run_default_test();
                int          c0;
                int          e0;
                int          flat_cnt;
                logic [31:0] rnd;
                c0 = check_cnt;
                e0 = err_cnt;
                flat_cnt = 0;
                repeat (DEFAULT_CYCLES) begin
                        rnd = $random(seed);
                        if (m_amp[rnd[3:0]] == 3'd7) begin
                                flat_cnt++;
                        end
                        step(rnd[3:0], 1'b0, 1'b0, 2'd0, 4'd0, 8'd0);
                end
                if (flat_cnt == 0) begin
                        note_failure("no colour without modulation was shown in the default test");
                end
                finish_test("default tables", c0, e0);
        endtask

        task automatic run_oddline_test();
                int          c0;
                int          e0;
                int          odd_cnt;
                int          even_cnt;
                logic [31:0] rnd;
                c0 = check_cnt;
                e0 = err_cnt;
                odd_cnt = 0;
                even_cnt = 0;
                repeat (ODD_CYCLES) begin
                        rnd = $random(seed);
                        if (m_phase[rnd[3:0]] != 8'd0) begin
                                if (line_is_odd(edge_no)) begin
                                        odd_cnt++;
                                end else begin
                                        even_cnt++;
                                end
                        end
                        step(rnd[3:0], 1'b0, 1'b0, 2'd0, 4'd0, 8'd0);
                end
                if (odd_cnt == 0 || even_cnt == 0) begin
                        note_failure("phased colours were not seen on both odd and even lines");
                end
                finish_test("odd-line mirroring", c0, e0);
        endtask

        task automatic run_blank_test();
                int          c0;
                int          e0;
                int          blank_cnt;
                logic [31:0] rnd;
                c0 = check_cnt;
                e0 = err_cnt;
                blank_cnt = 0;
                repeat (BLANK_CYCLES) begin
                        rnd = $random(seed);
                        if (rnd[4]) begin
                                blank_cnt++;
                        end
                        step(rnd[3:0], rnd[4], 1'b0, 2'd0, 4'd0, 8'd0);
                end
                if (blank_cnt == 0) begin
                        note_failure("blanking was never asserted in the blank test");
                end
                finish_test("blanking", c0, e0);
        endtask

        task automatic run_write_test();
                int          c0;
                int          e0;
                logic [31:0] rnd;
                logic [31:0] wr;
                c0 = check_cnt;
                e0 = err_cnt;
                repeat (WRITE_CYCLES) begin
                        rnd = $random(seed);
                        wr  = $random(seed);
                        step(rnd[3:0], 1'b0, rnd[9:8] != 2'b00, 2'(wr % 32'd3),
                             wr[11:8], wr[23:16]);
                end
                finish_test("table writes", c0, e0);
        endtask

        task automatic drain_pipeline();
                int exp_v;
                repeat (DRAIN_CYCLES) begin
                        @(negedge clk_dot4x);
                        exp_v = exp_q.pop_front();
                        check_value(exp_v, composite_o, "composite sample");
                        index_i  = '0;
                        blank_i  = 1'b0;
                        tbl_we_i = 1'b0;
                end
        endtask

        initial begin
                clk_dot4x  = 1'b0;
                rst_n_i    = 1'b0;
                index_i    = '0;
                blank_i    = 1'b0;
                tbl_we_i   = 1'b0;
                tbl_sel_i  = composite_pkg::sel_luma;
                tbl_addr_i = '0;
                tbl_data_i = '0;
                seed       = 29;
                edge_no    = 1;
                m_luma     = composite_pkg::DEFAULT_LUMA;
                m_amp      = composite_pkg::DEFAULT_AMP;
                m_phase    = composite_pkg::DEFAULT_PHASE;

                run_reset_test();
                run_default_test();
                run_oddline_test();
                run_blank_test();
                run_write_test();
                drain_pipeline();

                $display("summary: %0d tests, %0d checks, %0d errors",
                         test_cnt, check_cnt, err_cnt);
                if (err_cnt == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule : composite_enc_tb

`default_nettype wire

// File: logic/chroma_gen.sv
`timescale 1ns/10ps
`default_nettype none

module chroma_gen #(
        parameter logic [15:0] SUBCARRIER_INC = 16'd14564
) (
        input  wire                         clk_dot4x,
        input  wire                         rst_n_i,
        input  wire composite_pkg::luma_t   luma_i,
        input  wire composite_pkg::amp_t    amp_i,
        input  wire composite_pkg::phase_t  phase_i,
        input  wire                         blank_i,
        output composite_pkg::chroma_t      chroma_o,
        output composite_pkg::luma_t        luma_o,
        output logic                        blank_o
);

        logic [15:0]            acc_q;        // subcarrier phase accumulator
        composite_pkg::phase_t  phase_sum;
        logic [5:0]             sine_idx;
        composite_pkg::chroma_t sine_s;
        composite_pkg::chroma_t chroma_next;

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n_i) begin
                        acc_q <= '0;
                end else begin
                        acc_q <= acc_q + SUBCARRIER_INC;
                end
        end

        assign phase_sum = acc_q[15:8] + phase_i;   // wraps mod 256
        assign sine_idx  = phase_sum[7:2];
        assign sine_s    = composite_pkg::SINE_TABLE[sine_idx];

        always_comb begin
                if (amp_i == 3'd7) begin
                        chroma_next = '0;             // no modulation
                end else begin
                        chroma_next = sine_s >>> amp_i;
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n_i) begin
                        chroma_o <= '0;
                        luma_o   <= '0;
                        blank_o  <= 1'b0;
                end else begin
                        chroma_o <= chroma_next;
                        luma_o   <= luma_i;
                        blank_o  <= blank_i;
                end
        end

endmodule : chroma_gen

`default_nettype wire

// File: logic/color_lut.sv
`timescale 1ns/10ps
`default_nettype none

module color_lut (
        input  wire                             clk_dot4x,
        input  wire                             rst_n_i,
        input  wire composite_pkg::color_idx_t  index_i,
        input  wire                             blank_i,
        input  wire                             oddline_i,
        input  wire composite_pkg::luma_t       luma_tbl_i  [16],
        input  wire composite_pkg::amp_t        amp_tbl_i   [16],
        input  wire composite_pkg::phase_t      phase_tbl_i [16],
        output composite_pkg::luma_t            luma_o,
        output composite_pkg::amp_t             amp_o,
        output composite_pkg::phase_t           phase_o,
        output logic                            blank_o
);

        composite_pkg::luma_t  luma_sel;
        composite_pkg::amp_t   amp_sel;
        composite_pkg::phase_t phase_sel;
        composite_pkg::phase_t phase_next;

        always_comb begin
                luma_sel  = luma_tbl_i[0];
                amp_sel   = amp_tbl_i[0];
                phase_sel = phase_tbl_i[0];
                case (composite_pkg::color_e'(index_i))
                        composite_pkg::black: begin
                                luma_sel  = luma_tbl_i[0];
                                amp_sel   = amp_tbl_i[0];
                                phase_sel = phase_tbl_i[0];
                        end
                        composite_pkg::white: begin
                                luma_sel  = luma_tbl_i[1];
                                amp_sel   = amp_tbl_i[1];
                                phase_sel = phase_tbl_i[1];
                        end
                        composite_pkg::red: begin
                                luma_sel  = luma_tbl_i[2];
                                amp_sel   = amp_tbl_i[2];
                                phase_sel = phase_tbl_i[2];
                        end
                        composite_pkg::cyan: begin
                                luma_sel  = luma_tbl_i[3];
                                amp_sel   = amp_tbl_i[3];
                                phase_sel = phase_tbl_i[3];
                        end
                        composite_pkg::purple: begin
                                luma_sel  = luma_tbl_i[4];
                                amp_sel   = amp_tbl_i[4];
                                phase_sel = phase_tbl_i[4];
                        end
                        composite_pkg::green: begin
                                luma_sel  = luma_tbl_i[5];
                                amp_sel   = amp_tbl_i[5];
                                phase_sel = phase_tbl_i[5];
                        end
                        composite_pkg::blue: begin
                                luma_sel  = luma_tbl_i[6];
                                amp_sel   = amp_tbl_i[6];
                                phase_sel = phase_tbl_i[6];
                        end
                        composite_pkg::yellow: begin
                                luma_sel  = luma_tbl_i[7];
                                amp_sel   = amp_tbl_i[7];
                                phase_sel = phase_tbl_i[7];
                        end
                        composite_pkg::orange: begin
                                luma_sel  = luma_tbl_i[8];
                                amp_sel   = amp_tbl_i[8];
                                phase_sel = phase_tbl_i[8];
                        end
                        composite_pkg::brown: begin
                                luma_sel  = luma_tbl_i[9];
                                amp_sel   = amp_tbl_i[9];
                                phase_sel = phase_tbl_i[9];
                        end
                        composite_pkg::pink: begin
                                luma_sel  = luma_tbl_i[10];
                                amp_sel   = amp_tbl_i[10];
                                phase_sel = phase_tbl_i[10];
                        end
                        composite_pkg::dark_grey: begin
                                luma_sel  = luma_tbl_i[11];
                                amp_sel   = amp_tbl_i[11];
                                phase_sel = phase_tbl_i[11];
                        end
                        composite_pkg::grey: begin
                                luma_sel  = luma_tbl_i[12];
                                amp_sel   = amp_tbl_i[12];
                                phase_sel = phase_tbl_i[12];
                        end
                        composite_pkg::light_green: begin
                                luma_sel  = luma_tbl_i[13];
                                amp_sel   = amp_tbl_i[13];
                                phase_sel = phase_tbl_i[13];
                        end
                        composite_pkg::light_blue: begin
                                luma_sel  = luma_tbl_i[14];
                                amp_sel   = amp_tbl_i[14];
                                phase_sel = phase_tbl_i[14];
                        end
                        composite_pkg::light_grey: begin
                                luma_sel  = luma_tbl_i[15];
                                amp_sel   = amp_tbl_i[15];
                                phase_sel = phase_tbl_i[15];
                        end
                        default: ;
                endcase
        end

        // pal style alternation, odd lines run the phase backwards
        assign phase_next = oddline_i ? 8'd0 - phase_sel : phase_sel;

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n_i) begin
                        luma_o  <= '0;
                        amp_o   <= '0;
                        phase_o <= '0;
                        blank_o <= 1'b0;
                end else begin
                        luma_o  <= luma_sel;
                        amp_o   <= amp_sel;
                        phase_o <= phase_next;
                        blank_o <= blank_i;
                end
        end

endmodule : color_lut

`default_nettype wire

// File: logic/color_table_regs.sv
`timescale 1ns/10ps
`default_nettype none

module color_table_regs (
        input  wire                             clk_dot4x,
        input  wire                             rst_n_i,
        input  wire                             tbl_we_i,
        input  wire composite_pkg::tbl_sel_e    tbl_sel_i,
        input  wire composite_pkg::color_idx_t  tbl_addr_i,
        input  wire [7:0]                       tbl_data_i,
        output composite_pkg::luma_t            luma_tbl_o  [16],
        output composite_pkg::amp_t             amp_tbl_o   [16],
        output composite_pkg::phase_t           phase_tbl_o [16]
);

        // all three tables come back to ntsc on reset
        always_ff @(posedge clk_dot4x) begin
                if (!rst_n_i) begin
                        luma_tbl_o  <= composite_pkg::DEFAULT_LUMA;
                        amp_tbl_o   <= composite_pkg::DEFAULT_AMP;
                        phase_tbl_o <= composite_pkg::DEFAULT_PHASE;
                end else if (tbl_we_i) begin
                        case (tbl_sel_i)
                                composite_pkg::sel_luma: begin
                                        luma_tbl_o[tbl_addr_i] <= tbl_data_i[5:0];
                                end
                                composite_pkg::sel_amp: begin
                                        amp_tbl_o[tbl_addr_i] <= tbl_data_i[2:0];
                                end
                                composite_pkg::sel_phase: begin
                                        phase_tbl_o[tbl_addr_i] <= tbl_data_i;
                                end
                                default: begin
                                        // unused select, write dropped
                                end
                        endcase
                end
        end

endmodule : color_table_regs

`default_nettype wire

// File: logic/composite_enc_top.sv
`timescale 1ns/10ps
`default_nettype none

module composite_enc_top #(
        parameter int          LINE_LEN       = 520,
        parameter logic [15:0] SUBCARRIER_INC = 16'd14564
) (
        input  wire                             clk_dot4x,
        input  wire                             rst_n_i,
        input  wire composite_pkg::color_idx_t  index_i,
        input  wire                             blank_i,
        input  wire                             tbl_we_i,
        input  wire composite_pkg::tbl_sel_e    tbl_sel_i,
        input  wire composite_pkg::color_idx_t  tbl_addr_i,
        input  wire [7:0]                       tbl_data_i,
        output composite_pkg::comp_t            composite_o
);

        composite_pkg::luma_t   luma_tbl  [16];
        composite_pkg::amp_t    amp_tbl   [16];
        composite_pkg::phase_t  phase_tbl [16];

        logic                   oddline;
        composite_pkg::luma_t   s1_luma;
        composite_pkg::amp_t    s1_amp;
        composite_pkg::phase_t  s1_phase;
        logic                   s1_blank;
        composite_pkg::chroma_t s2_chroma;
        composite_pkg::luma_t   s2_luma;
        logic                   s2_blank;

        color_table_regs u_tables (
                .clk_dot4x   (clk_dot4x),
                .rst_n_i     (rst_n_i),
                .tbl_we_i    (tbl_we_i),
                .tbl_sel_i   (tbl_sel_i),
                .tbl_addr_i  (tbl_addr_i),
                .tbl_data_i  (tbl_data_i),
                .luma_tbl_o  (luma_tbl),
                .amp_tbl_o   (amp_tbl),
                .phase_tbl_o (phase_tbl)
        );

        line_timer #(
                .LINE_LEN (LINE_LEN)
        ) u_line_timer (
                .clk_dot4x (clk_dot4x),
                .rst_n_i   (rst_n_i),
                .oddline_o (oddline)
        );

        // stage 1
        color_lut u_lut (
                .clk_dot4x   (clk_dot4x),
                .rst_n_i     (rst_n_i),
                .index_i     (index_i),
                .blank_i     (blank_i),
                .oddline_i   (oddline),
                .luma_tbl_i  (luma_tbl),
                .amp_tbl_i   (amp_tbl),
                .phase_tbl_i (phase_tbl),
                .luma_o      (s1_luma),
                .amp_o       (s1_amp),
                .phase_o     (s1_phase),
                .blank_o     (s1_blank)
        );

        // stage 2
        chroma_gen #(
                .SUBCARRIER_INC (SUBCARRIER_INC)
        ) u_chroma (
                .clk_dot4x (clk_dot4x),
                .rst_n_i   (rst_n_i),
                .luma_i    (s1_luma),
                .amp_i     (s1_amp),
                .phase_i   (s1_phase),
                .blank_i   (s1_blank),
                .chroma_o  (s2_chroma),
                .luma_o    (s2_luma),
                .blank_o   (s2_blank)
        );

        // stage 3
        composite_mixer u_mixer (
                .clk_dot4x   (clk_dot4x),
                .rst_n_i     (rst_n_i),
                .luma_i      (s2_luma),
                .chroma_i    (s2_chroma),
                .blank_i     (s2_blank),
                .composite_o (composite_o)
        );

endmodule : composite_enc_top

`default_nettype wire

// File: logic/composite_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module composite_mixer (
        input  wire                          clk_dot4x,
        input  wire                          rst_n_i,
        input  wire composite_pkg::luma_t    luma_i,
        input  wire composite_pkg::chroma_t  chroma_i,
        input  wire                          blank_i,
        output composite_pkg::comp_t         composite_o
);

        composite_pkg::comp_t sum;

        // luma scaled by 4, chroma sign extended into the offset sum
        assign sum = composite_pkg::comp_t'({luma_i, 2'b00})
                   + composite_pkg::CHROMA_OFFSET
                   + composite_pkg::comp_t'(chroma_i);

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n_i) begin
                        composite_o <= '0;
                end else if (blank_i) begin
                        composite_o <= composite_pkg::BLANK_LEVEL;
                end else begin
                        composite_o <= sum;
                end
        end

endmodule : composite_mixer

`default_nettype wire

// File: logic/composite_pkg.sv
`default_nettype none

package composite_pkg;

        typedef logic [3:0]        color_idx_t;
        typedef logic [5:0]        luma_t;
        typedef logic [2:0]        amp_t;     // 0 strongest, 7 no modulation
        typedef logic [7:0]        phase_t;   // 256 steps per turn
        typedef logic signed [6:0] chroma_t;
        typedef logic [8:0]        comp_t;

        typedef enum logic [3:0] {
                black       = 4'd0,
                white       = 4'd1,
                red         = 4'd2,
                cyan        = 4'd3,
                purple      = 4'd4,
                green       = 4'd5,
                blue        = 4'd6,
                yellow      = 4'd7,
                orange      = 4'd8,
                brown       = 4'd9,
                pink        = 4'd10,
                dark_grey   = 4'd11,
                grey        = 4'd12,
                light_green = 4'd13,
                light_blue  = 4'd14,
                light_grey  = 4'd15
        } color_e;

        typedef enum logic [1:0] {
                sel_luma  = 2'd0,
                sel_amp   = 2'd1,
                sel_phase = 2'd2
        } tbl_sel_e;

        // ntsc defaults, entry n belongs to colour n
        localparam luma_t DEFAULT_LUMA [16] = '{
                6'd19, 6'd59, 6'd31, 6'd44, 6'd34, 6'd39, 6'd28, 6'd50,
                6'd34, 6'd28, 6'd39, 6'd31, 6'd38, 6'd50, 6'd38, 6'd44
        };

        localparam amp_t DEFAULT_AMP [16] = '{
                3'd7, 3'd7, 3'd2, 3'd2, 3'd1, 3'd1, 3'd2, 3'd0,
                3'd0, 3'd2, 3'd2, 3'd7, 3'd7, 3'd2, 3'd2, 3'd7
        };

        localparam phase_t DEFAULT_PHASE [16] = '{
                8'd0,   8'd0,   8'd80,  8'd208, 8'd32,  8'd160, 8'd0,   8'd128,
                8'd96,  8'd112, 8'd80,  8'd0,   8'd0,   8'd160, 8'd0,   8'd0
        };

        // one full period, 64 samples, peak 63
        localparam chroma_t SINE_TABLE [64] = '{
                7'sd0,   7'sd6,   7'sd12,  7'sd18,  7'sd24,  7'sd30,  7'sd35,  7'sd40,
                7'sd45,  7'sd49,  7'sd52,  7'sd56,  7'sd58,  7'sd60,  7'sd62,  7'sd63,
                7'sd63,  7'sd63,  7'sd62,  7'sd60,  7'sd58,  7'sd56,  7'sd52,  7'sd49,
                7'sd45,  7'sd40,  7'sd35,  7'sd30,  7'sd24,  7'sd18,  7'sd12,  7'sd6,
                7'sd0,   -7'sd6,  -7'sd12, -7'sd18, -7'sd24, -7'sd30, -7'sd35, -7'sd40,
                -7'sd45, -7'sd49, -7'sd52, -7'sd56, -7'sd58, -7'sd60, -7'sd62, -7'sd63,
                -7'sd63, -7'sd63, -7'sd62, -7'sd60, -7'sd58, -7'sd56, -7'sd52, -7'sd49,
                -7'sd45, -7'sd40, -7'sd35, -7'sd30, -7'sd24, -7'sd18, -7'sd12, -7'sd6
        };

        localparam comp_t CHROMA_OFFSET = 9'd64;  // keeps the sum unsigned
        localparam comp_t BLANK_LEVEL   = 9'd76;

endpackage : composite_pkg

`default_nettype wire

// File: logic/line_timer.sv
`timescale 1ns/10ps
`default_nettype none

module line_timer #(
        parameter int LINE_LEN = 520
) (
        input  wire   clk_dot4x,
        input  wire   rst_n_i,
        output logic  oddline_o
);

        localparam int CNT_W = $clog2(LINE_LEN);

        logic [CNT_W-1:0] pix_cnt_q;
        logic             line_end;

        assign line_end = (pix_cnt_q == CNT_W'(LINE_LEN - 1));

        always_ff @(posedge clk_dot4x) begin
                if (!rst_n_i) begin
                        pix_cnt_q <= '0;
                end else if (line_end) begin
                        pix_cnt_q <= '0;               // wrap to start of next line
                end else begin
                        pix_cnt_q <= pix_cnt_q + 1'b1;
                end
        end

        // line parity flips on the wrap edge
        always_ff @(posedge clk_dot4x) begin
                if (!rst_n_i) begin
                        oddline_o <= 1'b0;
                end else if (line_end) begin
                        oddline_o <= ~oddline_o;
                end
        end

endmodule : line_timer

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module composite_enc_tb -f composite_enc.f -o composite_enc_sim
out=$(./obj_dir/composite_enc_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
        echo "simulation passed"
else
        echo "simulation failed"
        exit 1
fi
